//--- hw/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data path width, only 32 supported
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_REG_COUNT 32

`endif

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

  typedef logic [31:0] rv_inst_t;
  typedef logic [4:0]  rv_reg_idx_t;

  // major opcodes of RV32I
  typedef enum logic [6:0] {
    RV_OPCODE_LUI    = 7'b0110111,
    RV_OPCODE_AUIPC  = 7'b0010111,
    RV_OPCODE_JAL    = 7'b1101111,
    RV_OPCODE_JALR   = 7'b1100111,
    RV_OPCODE_BRANCH = 7'b1100011,
    RV_OPCODE_LOAD   = 7'b0000011,
    RV_OPCODE_STORE  = 7'b0100011,
    RV_OPCODE_OP_IMM = 7'b0010011,
    RV_OPCODE_OP     = 7'b0110011
  } rv_opcode_e;

  typedef enum logic [2:0] {
    RV_FMT_R,
    RV_FMT_I,
    RV_FMT_S,
    RV_FMT_B,
    RV_FMT_U,
    RV_FMT_J
  } rv_format_e;

  typedef struct packed {
    logic [6:0]  funct7;
    rv_reg_idx_t rs2;
    rv_reg_idx_t rs1;
    logic [2:0]  funct3;
    rv_reg_idx_t rd;
    rv_opcode_e  opcode;
  } rv_inst_r_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    rv_reg_idx_t rs1;
    logic [2:0]  funct3;
    rv_reg_idx_t rd;
    rv_opcode_e  opcode;
  } rv_inst_i_t;

  typedef struct packed {
    logic [6:0]  imm_11_5;
    rv_reg_idx_t rs2;
    rv_reg_idx_t rs1;
    logic [2:0]  funct3;
    logic [4:0]  imm_4_0;
    rv_opcode_e  opcode;
  } rv_inst_s_t;

  typedef struct packed {
    logic        imm_12;
    logic [5:0]  imm_10_5;
    rv_reg_idx_t rs2;
    rv_reg_idx_t rs1;
    logic [2:0]  funct3;
    logic [3:0]  imm_4_1;
    logic        imm_11;
    rv_opcode_e  opcode;
  } rv_inst_b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    rv_reg_idx_t rd;
    rv_opcode_e  opcode;
  } rv_inst_u_t;

  typedef struct packed {
    logic        imm_20;
    logic [9:0]  imm_10_1;
    logic        imm_11;
    logic [7:0]  imm_19_12;
    rv_reg_idx_t rd;
    rv_opcode_e  opcode;
  } rv_inst_j_t;

endpackage

//--- hw/rv_core_pkg.sv
`include "rv_settings.svh"

package rv_core_pkg;

  import rv_isa_pkg::*;

  typedef logic [`RV_XLEN-1:0] rv_word_t;

  typedef enum logic [3:0] {
    RV_ALU_NONE,
    RV_ALU_ADD,
    RV_ALU_SUB,
    RV_ALU_SLL,
    RV_ALU_SLT,
    RV_ALU_SLTU,
    RV_ALU_XOR,
    RV_ALU_SRL,
    RV_ALU_SRA,
    RV_ALU_OR,
    RV_ALU_AND
  } rv_alu_cmd_e;

  // operand select for the two alu inputs
  typedef enum logic [1:0] {
    RV_ALU_SRC_RS,
    RV_ALU_SRC_IMM,
    RV_ALU_SRC_PC,
    RV_ALU_SRC_ZERO
  } rv_alu_src_e;

  typedef enum logic [1:0] {
    RV_MEM_NONE,
    RV_MEM_LOAD,
    RV_MEM_STORE
  } rv_mem_access_e;

  // what the id stage hands to execute
  typedef struct packed {
    logic           valid;
    rv_word_t       pc;
    rv_reg_idx_t    rs1;
    rv_reg_idx_t    rs2;
    rv_reg_idx_t    rd;
    rv_word_t       rs1_value;
    rv_word_t       rs2_value;
    rv_word_t       imm;
    rv_alu_cmd_e    alu_cmd;
    rv_alu_src_e    alu_src1;
    rv_alu_src_e    alu_src2;
    rv_mem_access_e mem_access;
    logic [2:0]     mem_width;
    logic           illegal;
  } rv_decode_rec_t;

endpackage

//--- hw/rv_decode_if.sv
`timescale 1ns/1ns

interface rv_decode_if
  import rv_isa_pkg::*, rv_core_pkg::*;
();
  logic           valid;
  rv_word_t       pc;
  rv_reg_idx_t    rs1;
  rv_reg_idx_t    rs2;
  rv_reg_idx_t    rd;
  rv_word_t       imm;
  rv_alu_cmd_e    alu_cmd;
  rv_alu_src_e    alu_src1;
  rv_alu_src_e    alu_src2;
  rv_mem_access_e mem_access;
  logic [2:0]     mem_width;  // funct3 as is
  logic           illegal;

  modport decoder (
    output valid, pc, rs1, rs2, rd, imm, alu_cmd, alu_src1, alu_src2,
           mem_access, mem_width, illegal
  );

  modport stage (
    input valid, pc, rs1, rs2, rd, imm, alu_cmd, alu_src1, alu_src2,
          mem_access, mem_width, illegal
  );
endinterface

//--- hw/rv_inst_decoder.sv
`timescale 1ns/1ns

module rv_inst_decoder
  import rv_isa_pkg::*, rv_core_pkg::*;
(
  input  logic         i_inst_valid,
  input  rv_inst_t     i_inst,
  input  rv_word_t     i_pc,
  rv_decode_if.decoder dec
);
  rv_inst_r_t     inst_r;
  rv_inst_i_t     inst_i;
  rv_inst_s_t     inst_s;
  rv_inst_b_t     inst_b;
  rv_inst_u_t     inst_u;
  rv_inst_j_t     inst_j;
  rv_format_e     fmt;
  rv_alu_cmd_e    cmd;
  rv_alu_src_e    src1;
  rv_alu_src_e    src2;
  rv_mem_access_e mem;
  logic           illegal;

  assign inst_r = rv_inst_r_t'(i_inst);
  assign inst_i = rv_inst_i_t'(i_inst);
  assign inst_s = rv_inst_s_t'(i_inst);
  assign inst_b = rv_inst_b_t'(i_inst);
  assign inst_u = rv_inst_u_t'(i_inst);
  assign inst_j = rv_inst_j_t'(i_inst);

  always_comb begin
    case (inst_r.opcode)
      RV_OPCODE_OP_IMM, RV_OPCODE_LOAD, RV_OPCODE_JALR: fmt = RV_FMT_I;
      RV_OPCODE_STORE:                                  fmt = RV_FMT_S;
      RV_OPCODE_BRANCH:                                 fmt = RV_FMT_B;
      RV_OPCODE_LUI, RV_OPCODE_AUIPC:                   fmt = RV_FMT_U;
      RV_OPCODE_JAL:                                    fmt = RV_FMT_J;
      default:                                          fmt = RV_FMT_R;  // OP and unknown
    endcase
  end

  always_comb begin
    case (fmt)
      RV_FMT_I: dec.imm = {{20{inst_i.imm_11_0[11]}}, inst_i.imm_11_0};
      RV_FMT_S: dec.imm = {{20{inst_s.imm_11_5[6]}}, inst_s.imm_11_5, inst_s.imm_4_0};
      RV_FMT_B: dec.imm = {{20{inst_b.imm_12}}, inst_b.imm_11, inst_b.imm_10_5,
                           inst_b.imm_4_1, 1'b0};
      RV_FMT_U: dec.imm = {inst_u.imm_31_12, 12'h000};
      RV_FMT_J: dec.imm = {{12{inst_j.imm_20}}, inst_j.imm_19_12, inst_j.imm_11,
                           inst_j.imm_10_1, 1'b0};
      default:  dec.imm = '0;
    endcase
  end

  always_comb begin
    cmd     = RV_ALU_ADD;
    src1    = RV_ALU_SRC_RS;
    src2    = RV_ALU_SRC_IMM;
    mem     = RV_MEM_NONE;
    illegal = 1'b0;
    case (inst_r.opcode)
      RV_OPCODE_LUI:   src1 = RV_ALU_SRC_ZERO;
      RV_OPCODE_AUIPC,
      RV_OPCODE_JAL:   src1 = RV_ALU_SRC_PC;
      RV_OPCODE_JALR: begin
        src1    = RV_ALU_SRC_PC;
        illegal = (inst_r.funct3 != 3'b000);
      end
      RV_OPCODE_BRANCH: begin
        src2 = RV_ALU_SRC_RS;
        case (inst_r.funct3)
          3'b000, 3'b001: cmd = RV_ALU_XOR;   // beq bne
          3'b100, 3'b101: cmd = RV_ALU_SLT;   // blt bge
          3'b110, 3'b111: cmd = RV_ALU_SLTU;  // bltu bgeu
          default:        illegal = 1'b1;
        endcase
      end
      RV_OPCODE_LOAD: begin
        mem     = RV_MEM_LOAD;
        illegal = !(inst_r.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
      end
      RV_OPCODE_STORE: begin
        mem     = RV_MEM_STORE;
        illegal = !(inst_r.funct3 inside {3'b000, 3'b001, 3'b010});
      end
      RV_OPCODE_OP_IMM: begin
        case (inst_r.funct3)
          3'b000: cmd = RV_ALU_ADD;
          3'b010: cmd = RV_ALU_SLT;
          3'b011: cmd = RV_ALU_SLTU;
          3'b100: cmd = RV_ALU_XOR;
          3'b110: cmd = RV_ALU_OR;
          3'b111: cmd = RV_ALU_AND;
          3'b001: begin
            cmd     = RV_ALU_SLL;
            illegal = (inst_r.funct7 != 7'b0000000);
          end
          default: begin
            // srli / srai share funct3
            cmd     = inst_r.funct7[5] ? RV_ALU_SRA : RV_ALU_SRL;
            illegal = (inst_r.funct7 & 7'b1011111) != 7'b0000000;
          end
        endcase
      end
      RV_OPCODE_OP: begin
        src2 = RV_ALU_SRC_RS;
        case ({inst_r.funct7, inst_r.funct3})
          {7'b0000000, 3'b000}: cmd = RV_ALU_ADD;
          {7'b0100000, 3'b000}: cmd = RV_ALU_SUB;
          {7'b0000000, 3'b001}: cmd = RV_ALU_SLL;
          {7'b0000000, 3'b010}: cmd = RV_ALU_SLT;
          {7'b0000000, 3'b011}: cmd = RV_ALU_SLTU;
          {7'b0000000, 3'b100}: cmd = RV_ALU_XOR;
          {7'b0000000, 3'b101}: cmd = RV_ALU_SRL;
          {7'b0100000, 3'b101}: cmd = RV_ALU_SRA;
          {7'b0000000, 3'b110}: cmd = RV_ALU_OR;
          {7'b0000000, 3'b111}: cmd = RV_ALU_AND;
          default:              illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase

    // anything not decoded is a bubble for execute
    if (illegal) begin
      cmd  = RV_ALU_NONE;
      src1 = RV_ALU_SRC_ZERO;
      src2 = RV_ALU_SRC_ZERO;
      mem  = RV_MEM_NONE;
    end
  end

  assign dec.valid      = i_inst_valid;
  assign dec.pc         = i_pc;
  assign dec.rs1        = (fmt inside {RV_FMT_U, RV_FMT_J}) ? '0 : inst_r.rs1;
  assign dec.rs2        = (fmt inside {RV_FMT_I, RV_FMT_U, RV_FMT_J}) ? '0 : inst_r.rs2;
  assign dec.rd         = (fmt inside {RV_FMT_S, RV_FMT_B}) ? '0 : inst_r.rd;
  assign dec.alu_cmd    = cmd;
  assign dec.alu_src1   = src1;
  assign dec.alu_src2   = src2;
  assign dec.mem_access = mem;
  assign dec.mem_width  = inst_r.funct3;
  assign dec.illegal    = illegal;

endmodule

//--- hw/rv_regfile.sv
`timescale 1ns/1ns

`include "rv_settings.svh"

module rv_regfile
  import rv_isa_pkg::*, rv_core_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_wb_valid,
  input  rv_reg_idx_t i_wb_rd,
  input  rv_word_t    i_wb_data,
  input  rv_reg_idx_t i_rs1_idx,
  input  rv_reg_idx_t i_rs2_idx,
  output rv_word_t    o_rs1_value,
  output rv_word_t    o_rs2_value
);
  rv_word_t regs [1:`RV_REG_COUNT-1];  // no storage for x0

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb_valid && (i_wb_rd != '0)) begin
      regs[i_wb_rd] <= i_wb_data;
    end
  end

  function automatic rv_word_t read_port(rv_reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end
    if (i_wb_valid && (i_wb_rd == idx)) begin
      return i_wb_data;  // bypass the write in flight
    end
    return regs[idx];
  endfunction

  assign o_rs1_value = read_port(i_rs1_idx);
  assign o_rs2_value = read_port(i_rs2_idx);

  // x0 stays zero on both ports, also across a write to it
  x0_reads_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    ((i_rs1_idx != '0) || (o_rs1_value == '0)) && ((i_rs2_idx != '0) || (o_rs2_value == '0)))
    else $error("x0 read returned nonzero data");

endmodule

//--- hw/rv_id_stage.sv
`timescale 1ns/1ns

module rv_id_stage
  import rv_isa_pkg::*, rv_core_pkg::*;
(
  input  logic           i_clk,
  input  logic           i_rst_n,
  input  logic           i_flush,
  rv_decode_if.stage     dec,
  input  rv_word_t       i_rs1_value,
  input  rv_word_t       i_rs2_value,
  input  logic           i_ex_valid,
  input  rv_reg_idx_t    i_ex_rd,
  input  rv_word_t       i_ex_data,
  output logic           o_id_valid,
  output rv_word_t       o_id_pc,
  output rv_reg_idx_t    o_id_rs1,
  output rv_reg_idx_t    o_id_rs2,
  output rv_reg_idx_t    o_id_rd,
  output rv_word_t       o_id_rs1_value,
  output rv_word_t       o_id_rs2_value,
  output rv_word_t       o_id_imm,
  output rv_alu_cmd_e    o_id_alu_cmd,
  output rv_alu_src_e    o_id_alu_src1,
  output rv_alu_src_e    o_id_alu_src2,
  output rv_mem_access_e o_id_mem_access,
  output logic [2:0]     o_id_mem_width,
  output logic           o_id_illegal
);
  rv_decode_rec_t id_q;

  // execute result beats the register file, write-through included
  function automatic rv_word_t pick_operand(rv_reg_idx_t idx, rv_word_t rf_value);
    if (idx == '0) begin
      return '0;  // index zeroed by format, or x0
    end
    if (i_ex_valid && (i_ex_rd == idx)) begin
      return i_ex_data;
    end
    return rf_value;
  endfunction

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      id_q <= '0;
    end else if (dec.valid && !i_flush) begin
      id_q.valid      <= 1'b1;
      id_q.pc         <= dec.pc;
      id_q.rs1        <= dec.rs1;
      id_q.rs2        <= dec.rs2;
      id_q.rd         <= dec.rd;
      id_q.rs1_value  <= pick_operand(dec.rs1, i_rs1_value);
      id_q.rs2_value  <= pick_operand(dec.rs2, i_rs2_value);
      id_q.imm        <= dec.imm;
      id_q.alu_cmd    <= dec.alu_cmd;
      id_q.alu_src1   <= dec.alu_src1;
      id_q.alu_src2   <= dec.alu_src2;
      id_q.mem_access <= dec.mem_access;
      id_q.mem_width  <= dec.mem_width;
      id_q.illegal    <= dec.illegal;
    end else begin
      id_q.valid <= 1'b0;  // payload holds
    end
  end

  assign o_id_valid      = id_q.valid;
  assign o_id_pc         = id_q.pc;
  assign o_id_rs1        = id_q.rs1;
  assign o_id_rs2        = id_q.rs2;
  assign o_id_rd         = id_q.rd;
  assign o_id_rs1_value  = id_q.rs1_value;
  assign o_id_rs2_value  = id_q.rs2_value;
  assign o_id_imm        = id_q.imm;
  assign o_id_alu_cmd    = id_q.alu_cmd;
  assign o_id_alu_src1   = id_q.alu_src1;
  assign o_id_alu_src2   = id_q.alu_src2;
  assign o_id_mem_access = id_q.mem_access;
  assign o_id_mem_width  = id_q.mem_width;
  assign o_id_illegal    = id_q.illegal;

  flush_drops_inst: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_flush |=> !o_id_valid)
    else $error("valid record in the cycle after a flush");

  // decoder must turn every illegal instruction into an alu bubble
  illegal_is_bubble: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_id_valid && o_id_illegal) |-> (o_id_alu_cmd == RV_ALU_NONE))
    else $error("illegal instruction carries an alu command");

endmodule

//--- hw/rv_decode_top.sv
`timescale 1ns/1ns

module rv_decode_top
  import rv_isa_pkg::*, rv_core_pkg::*;
(
  input  logic           i_clk,
  input  logic           i_rst_n,
  input  logic           i_inst_valid,
  input  rv_inst_t       i_inst,
  input  rv_word_t       i_pc,
  input  logic           i_flush,
  input  logic           i_wb_valid,
  input  rv_reg_idx_t    i_wb_rd,
  input  rv_word_t       i_wb_data,
  input  logic           i_ex_valid,
  input  rv_reg_idx_t    i_ex_rd,
  input  rv_word_t       i_ex_data,
  output logic           o_id_valid,
  output rv_word_t       o_id_pc,
  output rv_reg_idx_t    o_id_rs1,
  output rv_reg_idx_t    o_id_rs2,
  output rv_reg_idx_t    o_id_rd,
  output rv_word_t       o_id_rs1_value,
  output rv_word_t       o_id_rs2_value,
  output rv_word_t       o_id_imm,
  output rv_alu_cmd_e    o_id_alu_cmd,
  output rv_alu_src_e    o_id_alu_src1,
  output rv_alu_src_e    o_id_alu_src2,
  output rv_mem_access_e o_id_mem_access,
  output logic [2:0]     o_id_mem_width,
  output logic           o_id_illegal
);
  rv_decode_if dec_if();

  rv_inst_r_t inst_fields;
  rv_word_t   rs1_value;
  rv_word_t   rs2_value;

  // regfile reads the raw source fields and not the zeroed ones
  assign inst_fields = rv_inst_r_t'(i_inst);

  rv_inst_decoder u_decoder (
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .i_pc         (i_pc),
    .dec          (dec_if.decoder)
  );

  rv_regfile u_regfile (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_wb_valid  (i_wb_valid),
    .i_wb_rd     (i_wb_rd),
    .i_wb_data   (i_wb_data),
    .i_rs1_idx   (inst_fields.rs1),
    .i_rs2_idx   (inst_fields.rs2),
    .o_rs1_value (rs1_value),
    .o_rs2_value (rs2_value)
  );

  rv_id_stage u_id_stage (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_flush         (i_flush),
    .dec             (dec_if.stage),
    .i_rs1_value     (rs1_value),
    .i_rs2_value     (rs2_value),
    .i_ex_valid      (i_ex_valid),
    .i_ex_rd         (i_ex_rd),
    .i_ex_data       (i_ex_data),
    .o_id_valid      (o_id_valid),
    .o_id_pc         (o_id_pc),
    .o_id_rs1        (o_id_rs1),
    .o_id_rs2        (o_id_rs2),
    .o_id_rd         (o_id_rd),
    .o_id_rs1_value  (o_id_rs1_value),
    .o_id_rs2_value  (o_id_rs2_value),
    .o_id_imm        (o_id_imm),
    .o_id_alu_cmd    (o_id_alu_cmd),
    .o_id_alu_src1   (o_id_alu_src1),
    .o_id_alu_src2   (o_id_alu_src2),
    .o_id_mem_access (o_id_mem_access),
    .o_id_mem_width  (o_id_mem_width),
    .o_id_illegal    (o_id_illegal)
  );

endmodule

//--- verification/tb_decode_table.svh
// columns: name, kind, inst, wb_rd, ex_rd, ex_data
//   then expected rs1, rs2, rd, imm, alu_cmd, alu_src1, alu_src2, mem_access, illegal
localparam int ROW_COUNT = 25;

row_t table_rows [ROW_COUNT] = '{
  '{"wr_x1", ROW_WRITE, 32'h0, 5'd1, 5'd0, 32'h0,
    5'd0, 5'd0, 5'd0, 32'h0, RV_ALU_NONE, RV_ALU_SRC_RS, RV_ALU_SRC_RS, RV_MEM_NONE, 1'b0},
  '{"wr_x2", ROW_WRITE, 32'h0, 5'd2, 5'd0, 32'h0,
    5'd0, 5'd0, 5'd0, 32'h0, RV_ALU_NONE, RV_ALU_SRC_RS, RV_ALU_SRC_RS, RV_MEM_NONE, 1'b0},
  '{"wr_x3", ROW_WRITE, 32'h0, 5'd3, 5'd0, 32'h0,
    5'd0, 5'd0, 5'd0, 32'h0, RV_ALU_NONE, RV_ALU_SRC_RS, RV_ALU_SRC_RS, RV_MEM_NONE, 1'b0},
  '{"wr_x0", ROW_WRITE, 32'h0, 5'd0, 5'd0, 32'h0,
    5'd0, 5'd0, 5'd0, 32'h0, RV_ALU_NONE, RV_ALU_SRC_RS, RV_ALU_SRC_RS, RV_MEM_NONE, 1'b0},
  // add x4, x1, x2
  '{"add_rr", ROW_INST, 32'h00208233, 5'd0, 5'd0, 32'h0,
    5'd1, 5'd2, 5'd4, 32'h0, RV_ALU_ADD, RV_ALU_SRC_RS, RV_ALU_SRC_RS, RV_MEM_NONE, 1'b0},
  // sub x5, x3, x1
  '{"sub_rr", ROW_INST, 32'h401182B3, 5'd0, 5'd0, 32'h0,
    5'd3, 5'd1, 5'd5, 32'h0, RV_ALU_SUB, RV_ALU_SRC_RS, RV_ALU_SRC_RS, RV_MEM_NONE, 1'b0},
  '{"addi_neg", ROW_INST, 32'hFFB08393, 5'd0, 5'd0, 32'h0,  // addi x7, x1, -5
    5'd1, 5'd0, 5'd7, 32'hFFFFFFFB, RV_ALU_ADD, RV_ALU_SRC_RS, RV_ALU_SRC_IMM, RV_MEM_NONE, 1'b0},
  '{"srai", ROW_INST, 32'h4071D413, 5'd0, 5'd0, 32'h0,  // srai x8, x3, 7
    5'd3, 5'd0, 5'd8, 32'h00000407, RV_ALU_SRA, RV_ALU_SRC_RS, RV_ALU_SRC_IMM, RV_MEM_NONE, 1'b0},
  '{"lw_pos", ROW_INST, 32'h00C12483, 5'd0, 5'd0, 32'h0,  // lw x9, 12(x2)
    5'd2, 5'd0, 5'd9, 32'h0000000C, RV_ALU_ADD, RV_ALU_SRC_RS, RV_ALU_SRC_IMM, RV_MEM_LOAD, 1'b0},
  '{"lbu_neg", ROW_INST, 32'hFFF0C503, 5'd0, 5'd0, 32'h0,  // lbu x10, -1(x1)
    5'd1, 5'd0, 5'd10, 32'hFFFFFFFF, RV_ALU_ADD, RV_ALU_SRC_RS, RV_ALU_SRC_IMM, RV_MEM_LOAD, 1'b0},
  '{"sw_neg", ROW_INST, 32'hFE21A623, 5'd0, 5'd0, 32'h0,  // sw x2, -20(x3)
    5'd3, 5'd2, 5'd0, 32'hFFFFFFEC, RV_ALU_ADD, RV_ALU_SRC_RS, RV_ALU_SRC_IMM, RV_MEM_STORE, 1'b0},
  '{"beq_neg", ROW_INST, 32'hFE2088E3, 5'd0, 5'd0, 32'h0,  // beq x1, x2, -16
    5'd1, 5'd2, 5'd0, 32'hFFFFFFF0, RV_ALU_XOR, RV_ALU_SRC_RS, RV_ALU_SRC_RS, RV_MEM_NONE, 1'b0},
  '{"bltu_pos", ROW_INST, 32'h003160E3, 5'd0, 5'd0, 32'h0,  // bltu x2, x3, 2048
    5'd2, 5'd3, 5'd0, 32'h00000800, RV_ALU_SLTU, RV_ALU_SRC_RS, RV_ALU_SRC_RS, RV_MEM_NONE, 1'b0},
  '{"lui", ROW_INST, 32'h800015B7, 5'd0, 5'd0, 32'h0,  // lui x11, 0x80001
    5'd0, 5'd0, 5'd11, 32'h80001000, RV_ALU_ADD, RV_ALU_SRC_ZERO, RV_ALU_SRC_IMM, RV_MEM_NONE, 1'b0},
  '{"auipc_neg", ROW_INST, 32'hFFFFF617, 5'd0, 5'd0, 32'h0,  // auipc x12, 0xfffff
    5'd0, 5'd0, 5'd12, 32'hFFFFF000, RV_ALU_ADD, RV_ALU_SRC_PC, RV_ALU_SRC_IMM, RV_MEM_NONE, 1'b0},
  '{"jal_neg", ROW_INST, 32'hFFDFF0EF, 5'd0, 5'd0, 32'h0,  // jal x1, -4
    5'd0, 5'd0, 5'd1, 32'hFFFFFFFC, RV_ALU_ADD, RV_ALU_SRC_PC, RV_ALU_SRC_IMM, RV_MEM_NONE, 1'b0},
  '{"jalr_pos", ROW_INST, 32'h064106E7, 5'd0, 5'd0, 32'h0,  // jalr x13, 100(x2)
    5'd2, 5'd0, 5'd13, 32'h00000064, RV_ALU_ADD, RV_ALU_SRC_PC, RV_ALU_SRC_IMM, RV_MEM_NONE, 1'b0},
  '{"mul_ill", ROW_INST, 32'h02208733, 5'd0, 5'd0, 32'h0,  // mul x14, x1, x2
    5'd1, 5'd2, 5'd14, 32'h0, RV_ALU_NONE, RV_ALU_SRC_ZERO, RV_ALU_SRC_ZERO, RV_MEM_NONE, 1'b1},
  '{"ecall_ill", ROW_INST, 32'h00000073, 5'd0, 5'd0, 32'h0,
    5'd0, 5'd0, 5'd0, 32'h0, RV_ALU_NONE, RV_ALU_SRC_ZERO, RV_ALU_SRC_ZERO, RV_MEM_NONE, 1'b1},
  // same-cycle writeback of x1
  '{"wt_rs1", ROW_INST, 32'h00208233, 5'd1, 5'd0, 32'h0,
    5'd1, 5'd2, 5'd4, 32'h0, RV_ALU_ADD, RV_ALU_SRC_RS, RV_ALU_SRC_RS, RV_MEM_NONE, 1'b0},
  '{"ex_rs1", ROW_EX, 32'h401182B3, 5'd0, 5'd3, 32'hDEADBEEF,
    5'd3, 5'd1, 5'd5, 32'h0, RV_ALU_SUB, RV_ALU_SRC_RS, RV_ALU_SRC_RS, RV_MEM_NONE, 1'b0},
  '{"ex_over_wt", ROW_EX, 32'h00208233, 5'd2, 5'd2, 32'h0F0F1234,
    5'd1, 5'd2, 5'd4, 32'h0, RV_ALU_ADD, RV_ALU_SRC_RS, RV_ALU_SRC_RS, RV_MEM_NONE, 1'b0},
  '{"ex_x0", ROW_EX, 32'h00200233, 5'd0, 5'd0, 32'h12345678,  // add x4, x0, x2
    5'd0, 5'd2, 5'd4, 32'h0, RV_ALU_ADD, RV_ALU_SRC_RS, RV_ALU_SRC_RS, RV_MEM_NONE, 1'b0},
  '{"flush_add", ROW_FLUSH, 32'h00208233, 5'd0, 5'd0, 32'h0,
    5'd1, 5'd2, 5'd4, 32'h0, RV_ALU_ADD, RV_ALU_SRC_RS, RV_ALU_SRC_RS, RV_MEM_NONE, 1'b0},
  '{"after_flush", ROW_INST, 32'hFFB08393, 5'd0, 5'd0, 32'h0,
    5'd1, 5'd0, 5'd7, 32'hFFFFFFFB, RV_ALU_ADD, RV_ALU_SRC_RS, RV_ALU_SRC_IMM, RV_MEM_NONE, 1'b0}
};

//--- verification/tb_decode_top.sv
`timescale 1ns/1ns

`include "rv_settings.svh"

module tb_decode_top
  import rv_isa_pkg::*, rv_core_pkg::*;
();
  typedef enum logic [1:0] {ROW_WRITE, ROW_INST, ROW_FLUSH, ROW_EX} row_kind_e;

  typedef struct {
    string          name;
    row_kind_e      kind;
    rv_inst_t       inst;
    rv_reg_idx_t    wb_rd;  // nonzero on an inst row means writeback in the same cycle
    rv_reg_idx_t    ex_rd;
    rv_word_t       ex_data;
    rv_reg_idx_t    rs1;
    rv_reg_idx_t    rs2;
    rv_reg_idx_t    rd;
    rv_word_t       imm;
    rv_alu_cmd_e    alu_cmd;
    rv_alu_src_e    alu_src1;
    rv_alu_src_e    alu_src2;
    rv_mem_access_e mem_access;
    logic           illegal;
  } row_t;

  `include "tb_decode_table.svh"

  localparam int RESET_CYCLES = 3;
  localparam int CYCLE_LIMIT  = 2 * ROW_COUNT + RESET_CYCLES + 20;

  logic           i_clk;
  logic           i_rst_n;
  logic           i_inst_valid;
  rv_inst_t       i_inst;
  rv_word_t       i_pc;
  logic           i_flush;
  logic           i_wb_valid;
  rv_reg_idx_t    i_wb_rd;
  rv_word_t       i_wb_data;
  logic           i_ex_valid;
  rv_reg_idx_t    i_ex_rd;
  rv_word_t       i_ex_data;
  logic           o_id_valid;
  rv_word_t       o_id_pc;
  rv_reg_idx_t    o_id_rs1;
  rv_reg_idx_t    o_id_rs2;
  rv_reg_idx_t    o_id_rd;
  rv_word_t       o_id_rs1_value;
  rv_word_t       o_id_rs2_value;
  rv_word_t       o_id_imm;
  rv_alu_cmd_e    o_id_alu_cmd;
  rv_alu_src_e    o_id_alu_src1;
  rv_alu_src_e    o_id_alu_src2;
  rv_mem_access_e o_id_mem_access;
  logic [2:0]     o_id_mem_width;
  logic           o_id_illegal;

  rv_word_t    shadow [`RV_REG_COUNT];  // what each register should hold
  logic [31:0] lfsr_state;
  int          cycle_count = 0;

  rv_decode_top uut (.*);

  always #4 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      fail_run($sformatf("timeout after %0d cycles, the table did not finish", CYCLE_LIMIT));
    end
  end

  // galois form, taps 32 30 26 25
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic draw_word(output rv_word_t w);
    w = '0;
    for (int b = 0; b < `RV_XLEN; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[`RV_XLEN-2:0], lfsr_state[0]};
    end
  endtask

  task automatic fail_run(string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(string test, string field, rv_word_t exp, rv_word_t act);
    if (act !== exp) begin
      fail_run($sformatf("[ERROR] %s %s: expected %h, actual %h", test, field, exp, act));
    end
  endtask

  task automatic check_idx(string test, string field, rv_reg_idx_t exp, rv_reg_idx_t act);
    if (act !== exp) begin
      fail_run($sformatf("[ERROR] %s %s: expected x%0d, actual x%0d", test, field, exp, act));
    end
  endtask

  task automatic check_cmd(string test, rv_alu_cmd_e exp, rv_alu_cmd_e act);
    if (act !== exp) begin
      fail_run($sformatf("[ERROR] %s alu_cmd: expected %s, actual %s (%h)",
                         test, exp.name(), act.name(), act));
    end
  endtask

  task automatic check_src(string test, string field, rv_alu_src_e exp, rv_alu_src_e act);
    if (act !== exp) begin
      fail_run($sformatf("[ERROR] %s %s: expected %s, actual %s (%h)",
                         test, field, exp.name(), act.name(), act));
    end
  endtask

  task automatic check_mem(string test, rv_mem_access_e exp, rv_mem_access_e act);
    if (act !== exp) begin
      fail_run($sformatf("[ERROR] %s mem_access: expected %s, actual %s (%h)",
                         test, exp.name(), act.name(), act));
    end
  endtask

  task automatic check_width(string test, logic [2:0] exp, logic [2:0] act);
    if (act !== exp) begin
      fail_run($sformatf("[ERROR] %s mem_width: expected %b, actual %b", test, exp, act));
    end
  endtask

  task automatic check_flag(string test, string field, logic exp, logic act);
    if (act !== exp) begin
      fail_run($sformatf("[ERROR] %s %s: expected %b, actual %b", test, field, exp, act));
    end
  endtask

  // forwarding order: x0, then execute, then writeback in flight, then stored value
  function automatic rv_word_t expected_operand(row_t row, rv_reg_idx_t idx, rv_word_t wb_data);
    if (idx == '0) begin
      return '0;
    end
    if (row.kind == ROW_EX && row.ex_rd != '0 && row.ex_rd == idx) begin
      return row.ex_data;
    end
    if (row.wb_rd != '0 && row.wb_rd == idx) begin
      return wb_data;
    end
    return shadow[idx];
  endfunction

  task automatic check_reset_state();
    check_flag("reset", "valid", 1'b0, o_id_valid);
    check_word("reset", "pc", '0, o_id_pc);
    check_idx("reset", "rs1", '0, o_id_rs1);
    check_idx("reset", "rs2", '0, o_id_rs2);
    check_idx("reset", "rd", '0, o_id_rd);
    check_word("reset", "rs1_value", '0, o_id_rs1_value);
    check_word("reset", "rs2_value", '0, o_id_rs2_value);
    check_word("reset", "imm", '0, o_id_imm);
    check_cmd("reset", RV_ALU_NONE, o_id_alu_cmd);
    check_src("reset", "alu_src1", RV_ALU_SRC_RS, o_id_alu_src1);
    check_src("reset", "alu_src2", RV_ALU_SRC_RS, o_id_alu_src2);
    check_mem("reset", RV_MEM_NONE, o_id_mem_access);
    check_width("reset", 3'b000, o_id_mem_width);
    check_flag("reset", "illegal", 1'b0, o_id_illegal);
  endtask

  task automatic check_record(row_t row, rv_word_t exp_pc, rv_word_t exp_rs1_value,
                              rv_word_t exp_rs2_value);
    check_flag(row.name, "valid", 1'b1, o_id_valid);
    check_word(row.name, "pc", exp_pc, o_id_pc);
    check_idx(row.name, "rs1", row.rs1, o_id_rs1);
    check_idx(row.name, "rs2", row.rs2, o_id_rs2);
    check_idx(row.name, "rd", row.rd, o_id_rd);
    check_word(row.name, "rs1_value", exp_rs1_value, o_id_rs1_value);
    check_word(row.name, "rs2_value", exp_rs2_value, o_id_rs2_value);
    check_word(row.name, "imm", row.imm, o_id_imm);
    check_cmd(row.name, row.alu_cmd, o_id_alu_cmd);
    check_src(row.name, "alu_src1", row.alu_src1, o_id_alu_src1);
    check_src(row.name, "alu_src2", row.alu_src2, o_id_alu_src2);
    check_mem(row.name, row.mem_access, o_id_mem_access);
    check_width(row.name, row.inst[14:12], o_id_mem_width);  // funct3 field
    check_flag(row.name, "illegal", row.illegal, o_id_illegal);
  endtask

  initial begin
    row_t     row;
    rv_word_t wb_data;
    rv_word_t exp_pc;
    rv_word_t exp_rs1_value;
    rv_word_t exp_rs2_value;
    logic     wb_on;

    i_clk        = 1'b0;
    i_rst_n      = 1'b0;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    i_pc         = '0;
    i_flush      = 1'b0;
    i_wb_valid   = 1'b0;
    i_wb_rd      = '0;
    i_wb_data    = '0;
    i_ex_valid   = 1'b0;
    i_ex_rd      = '0;
    i_ex_data    = '0;
    lfsr_state   = 32'h4924_c52d;
    for (int r = 0; r < `RV_REG_COUNT; r++) begin
      shadow[r] = '0;
    end

    repeat (RESET_CYCLES) @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(negedge i_clk);
    check_reset_state();

    for (int n = 0; n < ROW_COUNT; n++) begin
      row     = table_rows[n];
      exp_pc  = 32'h0000_1000 + 32'(4 * n);
      wb_on   = (row.kind == ROW_WRITE) || (row.wb_rd != '0);
      wb_data = '0;
      if (wb_on) begin
        draw_word(wb_data);
      end

      @(posedge i_clk);
      i_inst_valid <= (row.kind != ROW_WRITE);
      i_inst       <= row.inst;
      i_pc         <= exp_pc;
      i_flush      <= (row.kind == ROW_FLUSH);
      i_wb_valid   <= wb_on;
      i_wb_rd      <= row.wb_rd;
      i_wb_data    <= wb_data;
      i_ex_valid   <= (row.kind == ROW_EX);
      i_ex_rd      <= row.ex_rd;
      i_ex_data    <= row.ex_data;

      exp_rs1_value = expected_operand(row, row.rs1, wb_data);
      exp_rs2_value = expected_operand(row, row.rs2, wb_data);
      if (wb_on && row.wb_rd != '0) begin
        shadow[row.wb_rd] = wb_data;  // x0 never changes
      end

      @(posedge i_clk);
      i_inst_valid <= 1'b0;
      i_flush      <= 1'b0;
      i_wb_valid   <= 1'b0;
      i_ex_valid   <= 1'b0;

      @(negedge i_clk);
      if (row.kind == ROW_INST || row.kind == ROW_EX) begin
        check_record(row, exp_pc, exp_rs1_value, exp_rs2_value);
      end else begin
        check_flag(row.name, "valid", 1'b0, o_id_valid);  // write only, or dropped by flush
      end
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+hw
+incdir+verification
hw/rv_isa_pkg.sv
hw/rv_core_pkg.sv
hw/rv_decode_if.sv
hw/rv_inst_decoder.sv
hw/rv_regfile.sv
hw/rv_id_stage.sv
hw/rv_decode_top.sv
verification/tb_decode_top.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_decode_top -f vlog.f

# the simulator exit status is dropped by the pipe, the log decides
./obj_dir/Vtb_decode_top | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  echo "run.sh: result ok"
  exit 0
fi
echo "run.sh: result bad, see sim.log"
exit 1
